// File: include/trap_defs.svh
`ifndef TRAP_DEFS_SVH
`define TRAP_DEFS_SVH

// data and pc width.
`define TRAP_DATA_W     32

// stages covered by the pause mask with bit 0 at fetch.
`define TRAP_STAGES     8

// exception source slots carried by one instruction.
`define TRAP_EXC_SRC    6

// interrupt vector width shared by ECFG.LIE and ESTAT.IS.
`define TRAP_INT_W      12
`define TRAP_HWI_W      8

`define TRAP_CSR_ADDR_W 14
`define TRAP_CAUSE_W    5
`define TRAP_ECODE_W    6
`define TRAP_ESUB_W     9

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the trap_unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_trap_unit \
    -f trap_unit.f \
    -Mdir obj_dir -o tb_trap_unit > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_trap_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// File: tests/tb_trap_unit.sv
`timescale 1ns/100ps
`include "trap_defs.svh"

module tb_trap_unit;
    import csr_types::*;
    import pipeline_types::*;

    localparam int                      TIMER_N  = 12;
    localparam int                      TIMEOUT  = 100;
    localparam logic [`TRAP_DATA_W-1:0] ENTRY    = 32'h1c00_8000;
    localparam mem_ctrl_t               NO_INSTR = '0;
    localparam pause_req_t              NO_PAUSE = '0;
    localparam wb_csr_t                 NO_WR    = '0;

    logic                    clk;
    logic                    rst_i;
    mem_ctrl_t               mem_i;
    pause_req_t              pause_req_i;
    logic                    continue_idle_i;
    wb_csr_t                 wb_i;
    logic [`TRAP_HWI_W-1:0]  hwi_i;
    csr_addr_e               csr_raddr_i;
    logic [`TRAP_DATA_W-1:0] csr_rdata_o;
    ctrl_out_t               ctrl_o;

    int ctrl_errs;
    int csr_errs;
    int other_errs;

    // stimulus and expected values, one index per table entry.
    string                   names[$];
    mem_ctrl_t               mems[$];
    pause_req_t              pauses[$];
    wb_csr_t                 wbs[$];
    logic [`TRAP_HWI_W-1:0]  hwis[$];
    csr_addr_e               raddrs[$];
    ctrl_out_t               exp_ctrls[$];
    logic                    now_chks[$];
    logic [`TRAP_DATA_W-1:0] exp_nows[$];
    logic [`TRAP_DATA_W-1:0] exp_nexts[$];

    trap_unit dut0 (
        .clk             (clk),
        .rst_i           (rst_i),
        .mem_i           (mem_i),
        .pause_req_i     (pause_req_i),
        .continue_idle_i (continue_idle_i),
        .wb_i            (wb_i),
        .hwi_i           (hwi_i),
        .csr_raddr_i     (csr_raddr_i),
        .csr_rdata_o     (csr_rdata_o),
        .ctrl_o          (ctrl_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic mem_ctrl_t exc_instr(input logic [`TRAP_DATA_W-1:0] pc,
                                            input logic [`TRAP_EXC_SRC-1:0] vec,
                                            input exc_cause_e c5, input exc_cause_e c2,
                                            input exc_cause_e c1, input exc_cause_e c0,
                                            input logic priv);
        mem_ctrl_t m;
        m = '0;
        m.pc           = pc;
        m.is_exception = vec;
        m.exc_cause[5] = c5;
        m.exc_cause[2] = c2;
        m.exc_cause[1] = c1;
        m.exc_cause[0] = c0;
        m.is_privilege = priv;
        return m;
    endfunction

    function automatic mem_ctrl_t ertn_instr(input logic [`TRAP_DATA_W-1:0] pc);
        mem_ctrl_t m;
        m = '0;
        m.pc      = pc;
        m.is_ertn = 1'b1;
        return m;
    endfunction

    function automatic mem_ctrl_t idle_instr();
        mem_ctrl_t m;
        m = '0;
        m.is_idle = 1'b1;
        return m;
    endfunction

    function automatic wb_csr_t csr_wr(input csr_addr_e addr, input logic [`TRAP_DATA_W-1:0] data);
        wb_csr_t w;
        w.en   = 1'b1;
        w.addr = addr;
        w.data = data;
        return w;
    endfunction

    task automatic add_test(input string name, input mem_ctrl_t mem, input pause_req_t pause,
                            input wb_csr_t wb, input logic [`TRAP_HWI_W-1:0] hwi,
                            input csr_addr_e raddr, input logic e_flush,
                            input logic [`TRAP_DATA_W-1:0] e_pc, input logic e_int,
                            input logic [`TRAP_STAGES-1:0] e_pause, input logic chk_now,
                            input logic [`TRAP_DATA_W-1:0] e_now,
                            input logic [`TRAP_DATA_W-1:0] e_next);
        ctrl_out_t c;
        c.flush        = e_flush;
        c.redirect_pc  = e_pc;
        c.is_interrupt = e_int;
        c.pause        = e_pause;
        names.push_back(name);
        mems.push_back(mem);
        pauses.push_back(pause);
        wbs.push_back(wb);
        hwis.push_back(hwi);
        raddrs.push_back(raddr);
        exp_ctrls.push_back(c);
        now_chks.push_back(chk_now);
        exp_nows.push_back(e_now);
        exp_nexts.push_back(e_next);
    endtask

    function automatic string ctrl_text(input ctrl_out_t c);
        return $sformatf("flush=%0b pc=%h int=%0b pause=%h",
                         c.flush, c.redirect_pc, c.is_interrupt, c.pause);
    endfunction

    task automatic check_ctrl(input string name, input ctrl_out_t exp, input ctrl_out_t act);
        if (act !== exp) begin
            ctrl_errs++;
            $display("[FAIL] %s: expected %s, actual %s", name, ctrl_text(exp), ctrl_text(act));
        end
    endtask

    task automatic check_csr(input string name, input logic [`TRAP_DATA_W-1:0] exp,
                             input logic [`TRAP_DATA_W-1:0] act);
        if (act !== exp) begin
            csr_errs++;
            $display("[FAIL] %s: expected csr=%h, actual csr=%h", name, exp, act);
        end
    endtask

    task automatic fill_table();
        // eentry write is visible in the same cycle through forwarding.
        add_test("eentry_fwd", NO_INSTR, NO_PAUSE, csr_wr(CSR_EENTRY, ENTRY), 8'h00, CSR_EENTRY,
                 1'b0, ENTRY, 1'b0, 8'h00, 1'b1, ENTRY, ENTRY);
        add_test("exc_slot5_wins",
                 exc_instr(32'h1c00_0100, 6'b100101, EXC_ALE, EXC_INE, EXC_NOP, EXC_PIF, 1'b0),
                 NO_PAUSE, NO_WR, 8'h00, CSR_ESTAT, 1'b1, ENTRY, 1'b0, 8'h00, 1'b0, '0, 32'h0009_0000);
        add_test("exc_adem_sub",
                 exc_instr(32'h1c00_0200, 6'b000011, EXC_NOP, EXC_NOP, EXC_ADEM, EXC_PIL, 1'b0),
                 NO_PAUSE, NO_WR, 8'h00, CSR_ESTAT, 1'b1, ENTRY, 1'b0, 8'h00, 1'b0, '0, 32'h0048_0000);
        add_test("exc_era_pc",
                 exc_instr(32'h1c00_0300, 6'b000001, EXC_NOP, EXC_NOP, EXC_NOP, EXC_SYS, 1'b0),
                 NO_PAUSE, NO_WR, 8'h00, CSR_ERA, 1'b1, ENTRY, 1'b0, 8'h00, 1'b0, '0, 32'h1c00_0300);
        add_test("crmd_plv3", NO_INSTR, NO_PAUSE, csr_wr(CSR_CRMD, 32'h0000_000b), 8'h00, CSR_CRMD,
                 1'b0, ENTRY, 1'b0, 8'h00, 1'b1, 32'h0000_000b, 32'h0000_000b);
        add_test("exc_ipe_plv3",
                 exc_instr(32'h1c00_0400, 6'b000100, EXC_NOP, EXC_INE, EXC_NOP, EXC_NOP, 1'b1),
                 NO_PAUSE, NO_WR, 8'h00, CSR_ESTAT, 1'b1, ENTRY, 1'b0, 8'h00, 1'b0, '0, 32'h000e_0000);
        add_test("exc_ine_plv0",
                 exc_instr(32'h1c00_0480, 6'b000100, EXC_NOP, EXC_INE, EXC_NOP, EXC_NOP, 1'b1),
                 NO_PAUSE, NO_WR, 8'h00, CSR_ESTAT, 1'b1, ENTRY, 1'b0, 8'h00, 1'b0, '0, 32'h000d_0000);
        // trap entry clears plv and ie, ertn brings them back from prmd.
        add_test("crmd_ie_plv3", NO_INSTR, NO_PAUSE, csr_wr(CSR_CRMD, 32'h0000_0007), 8'h00, CSR_CRMD,
                 1'b0, ENTRY, 1'b0, 8'h00, 1'b0, '0, 32'h0000_0007);
        add_test("trap_crmd",
                 exc_instr(32'h1c00_0500, 6'b000001, EXC_NOP, EXC_NOP, EXC_NOP, EXC_SYS, 1'b0),
                 NO_PAUSE, NO_WR, 8'h00, CSR_CRMD, 1'b1, ENTRY, 1'b0, 8'h00, 1'b0, '0, 32'h0000_0000);
        add_test("trap_prmd", NO_INSTR, NO_PAUSE, NO_WR, 8'h00, CSR_PRMD,
                 1'b0, ENTRY, 1'b0, 8'h00, 1'b1, 32'h0000_0007, 32'h0000_0007);
        add_test("ertn_restore", ertn_instr(32'h1c00_0600), NO_PAUSE, NO_WR, 8'h00, CSR_CRMD,
                 1'b1, 32'h1c00_0500, 1'b0, 8'h00, 1'b0, '0, 32'h0000_0007);
        // request bits are {if, id, dispatch, ex, mem}.
        add_test("pause_if", NO_INSTR, pause_req_t'(5'b10000), NO_WR, 8'h00, CSR_CRMD,
                 1'b0, ENTRY, 1'b0, 8'h01, 1'b0, '0, 32'h0000_0007);
        add_test("pause_id", NO_INSTR, pause_req_t'(5'b01000), NO_WR, 8'h00, CSR_CRMD,
                 1'b0, ENTRY, 1'b0, 8'h0f, 1'b0, '0, 32'h0000_0007);
        add_test("pause_id_if", NO_INSTR, pause_req_t'(5'b11000), NO_WR, 8'h00, CSR_CRMD,
                 1'b0, ENTRY, 1'b0, 8'h0f, 1'b0, '0, 32'h0000_0007);
        add_test("pause_dispatch", NO_INSTR, pause_req_t'(5'b00100), NO_WR, 8'h00, CSR_CRMD,
                 1'b0, ENTRY, 1'b0, 8'h1f, 1'b0, '0, 32'h0000_0007);
        add_test("pause_ex_id", NO_INSTR, pause_req_t'(5'b01010), NO_WR, 8'h00, CSR_CRMD,
                 1'b0, ENTRY, 1'b0, 8'h3f, 1'b0, '0, 32'h0000_0007);
        add_test("pause_mem_if", NO_INSTR, pause_req_t'(5'b10001), NO_WR, 8'h00, CSR_CRMD,
                 1'b0, ENTRY, 1'b0, 8'h7f, 1'b0, '0, 32'h0000_0007);
        add_test("pause_all", NO_INSTR, pause_req_t'(5'b11111), NO_WR, 8'h00, CSR_CRMD,
                 1'b0, ENTRY, 1'b0, 8'h7f, 1'b0, '0, 32'h0000_0007);
        add_test("pause_idle", idle_instr(), NO_PAUSE, NO_WR, 8'h00, CSR_CRMD,
                 1'b0, ENTRY, 1'b0, 8'h7f, 1'b0, '0, 32'h0000_0007);
        // hwi line 0 lands in estat.is bit 2.
        add_test("hwi_lie_set", NO_INSTR, NO_PAUSE, csr_wr(CSR_ECFG, 32'h0000_0004), 8'h01, CSR_ECFG,
                 1'b0, ENTRY, 1'b0, 8'h00, 1'b0, '0, 32'h0000_0004);
        add_test("hwi_idle_wake", idle_instr(), NO_PAUSE, NO_WR, 8'h01, CSR_ESTAT,
                 1'b0, ENTRY, 1'b1, 8'h00, 1'b1, 32'h000b_0004, 32'h000b_0004);
        add_test("hwi_no_ie", idle_instr(), NO_PAUSE, csr_wr(CSR_CRMD, 32'h0000_0003), 8'h01,
                 CSR_CRMD, 1'b0, ENTRY, 1'b0, 8'h7f, 1'b0, '0, 32'h0000_0003);
        add_test("hwi_clear", NO_INSTR, NO_PAUSE, csr_wr(CSR_ECFG, 32'h0), 8'h00, CSR_ESTAT,
                 1'b0, ENTRY, 1'b0, 8'h00, 1'b0, '0, 32'h000b_0000);
    endtask

    // one entry takes two cycles, stimulus first and then a quiet cycle for readback.
    task automatic run_entry(input int i);
        @(posedge clk);
        mem_i       <= mems[i];
        pause_req_i <= pauses[i];
        wb_i        <= wbs[i];
        hwi_i       <= hwis[i];
        csr_raddr_i <= raddrs[i];
        @(negedge clk);
        check_ctrl(names[i], exp_ctrls[i], ctrl_o);
        if (now_chks[i]) begin
            check_csr(names[i], exp_nows[i], csr_rdata_o);
        end
        @(posedge clk);
        mem_i       <= NO_INSTR;
        pause_req_i <= NO_PAUSE;
        wb_i        <= NO_WR;
        @(negedge clk);
        check_csr({names[i], " next"}, exp_nexts[i], csr_rdata_o);
    endtask

    task automatic run_timer();
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        @(posedge clk);
        // one-shot timer whose count is tcfg with the two mode bits cleared.
        wb_i        <= csr_wr(CSR_TCFG, 32'(TIMER_N) | 32'h1);
        csr_raddr_i <= CSR_ESTAT;
        while (!seen && cycles < TIMEOUT) begin
            @(posedge clk);
            wb_i <= NO_WR;
            cycles++;
            @(negedge clk);
            seen = csr_rdata_o[11];
        end
        if (!seen) begin
            other_errs++;
            $display("timer interrupt did not reach ESTAT within %0d cycles", TIMEOUT);
        end else if (cycles < TIMER_N) begin
            other_errs++;
            $display("timer interrupt reached ESTAT after only %0d cycles, count was %0d",
                     cycles, TIMER_N);
        end
        check_csr("timer_estat", 32'h000b_0800, csr_rdata_o);
        @(posedge clk);
        csr_raddr_i <= CSR_TVAL;
        @(negedge clk);
        check_csr("timer_tval_stop", 32'hffff_ffff, csr_rdata_o);
        @(posedge clk);
        wb_i        <= csr_wr(CSR_TICLR, 32'h1);
        csr_raddr_i <= CSR_ESTAT;
        @(posedge clk);
        wb_i <= NO_WR;
        @(negedge clk);
        check_csr("timer_ticlr", 32'h000b_0000, csr_rdata_o);
    endtask

    initial begin
        rst_i           = 1'b1;
        mem_i           = NO_INSTR;
        pause_req_i     = NO_PAUSE;
        continue_idle_i = 1'b0;
        wb_i            = NO_WR;
        hwi_i           = '0;
        csr_raddr_i     = CSR_CRMD;
        ctrl_errs       = 0;
        csr_errs        = 0;
        other_errs      = 0;
        fill_table();
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        for (int i = 0; i < names.size(); i++) begin
            run_entry(i);
        end
        run_timer();
        $display("error counts: ctrl %0d, csr %0d, other %0d", ctrl_errs, csr_errs, other_errs);
        if (ctrl_errs + csr_errs + other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: trap_unit.f
+incdir+include
verilog/csr_types.sv
verilog/pipeline_types.sv
verilog/ctrl.sv
verilog/csr_file.sv
verilog/timer_unit.sv
verilog/trap_unit.sv
tests/tb_trap_unit.sv

// File: verilog/csr_file.sv
`timescale 1ns/100ps
`include "trap_defs.svh"

module csr_file (
    input  logic                      clk,
    input  logic                      rst_i,
    input  pipeline_types::wb_csr_t   wb_i,
    input  csr_types::trap_commit_t   commit_i,
    input  logic [`TRAP_HWI_W-1:0]    hwi_i,
    input  logic                      timer_irq_i,
    input  logic [`TRAP_DATA_W-1:0]   tval_i,
    input  csr_types::csr_addr_e      raddr_i,
    output logic [`TRAP_DATA_W-1:0]   rdata_o,
    output csr_types::csr_view_t      view_o,
    output logic [`TRAP_DATA_W-1:0]   tcfg_o,
    output logic                      tcfg_wr_o
);
    import csr_types::*;
    import pipeline_types::*;

    // implemented interrupt bits with bit 10 reserved.
    localparam logic [`TRAP_DATA_W-1:0] IS_MASK = 32'h0000_1bff;

    logic [`TRAP_DATA_W-1:0] crmd, prmd, ecfg, estat, era, eentry, tcfg;
    logic [`TRAP_DATA_W-1:0] crmd_cur, prmd_cur, ecfg_cur, estat_cur;
    logic [`TRAP_DATA_W-1:0] era_cur, eentry_cur, tcfg_cur;
    logic                    ticlr_wr;

    function automatic logic [`TRAP_DATA_W-1:0] fwd(
        input wb_csr_t                 wb,
        input csr_addr_e               addr,
        input logic [`TRAP_DATA_W-1:0] cur
    );
        return (wb.en && wb.addr == addr) ? wb.data : cur;
    endfunction

    assign crmd_cur   = fwd(wb_i, CSR_CRMD, crmd);
    assign prmd_cur   = fwd(wb_i, CSR_PRMD, prmd);
    assign era_cur    = fwd(wb_i, CSR_ERA, era);
    assign eentry_cur = fwd(wb_i, CSR_EENTRY, eentry);
    assign tcfg_cur   = fwd(wb_i, CSR_TCFG, tcfg);
    assign ecfg_cur   = fwd(wb_i, CSR_ECFG, ecfg) & IS_MASK;
    assign estat_cur  = (fwd(wb_i, CSR_ESTAT, estat) & IS_MASK) | (estat & ~IS_MASK);

    assign view_o.crmd     = crmd_cur;
    assign view_o.era      = era_cur;
    assign view_o.eentry   = eentry_cur;
    assign view_o.ecfg_lie = {ecfg_cur[12:11], ecfg_cur[9:0]};
    assign view_o.estat_is = {estat_cur[12:11], estat_cur[9:0]};

    assign tcfg_o    = tcfg_cur;
    assign tcfg_wr_o = wb_i.en && wb_i.addr == CSR_TCFG;
    assign ticlr_wr  = wb_i.en && wb_i.addr == CSR_TICLR;

    always_comb begin
        case (raddr_i)
            CSR_CRMD:   rdata_o = crmd_cur;
            CSR_PRMD:   rdata_o = prmd_cur;
            CSR_ECFG:   rdata_o = ecfg_cur;
            CSR_ESTAT:  rdata_o = estat_cur;
            CSR_ERA:    rdata_o = era_cur;
            CSR_EENTRY: rdata_o = eentry_cur;
            CSR_TCFG:   rdata_o = tcfg_cur;
            CSR_TVAL:   rdata_o = tval_i;
            default:    rdata_o = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            crmd   <= 32'h0000_0008;
            prmd   <= '0;
            ecfg   <= '0;
            estat  <= '0;
            era    <= '0;
            eentry <= '0;
            tcfg   <= '0;
        end else begin
            if (wb_i.en) begin
                case (wb_i.addr)
                    CSR_CRMD:   crmd   <= wb_i.data;
                    CSR_PRMD:   prmd   <= wb_i.data;
                    CSR_ECFG:   ecfg   <= wb_i.data & IS_MASK;
                    CSR_ESTAT:  estat  <= estat_cur;
                    CSR_ERA:    era    <= wb_i.data;
                    CSR_EENTRY: eentry <= wb_i.data;
                    CSR_TCFG:   tcfg   <= wb_i.data;
                    default: ;
                endcase
            end
            estat[9:2] <= hwi_i;
            if (ticlr_wr) begin
                estat[11] <= 1'b0;
            end
            if (timer_irq_i) begin
                estat[11] <= 1'b1;
            end
            // the commit comes last so it overrides a same-cycle write.
            if (commit_i.valid) begin
                if (commit_i.ertn) begin
                    crmd[2:0] <= prmd_cur[2:0];
                end else begin
                    prmd[2:0]    <= crmd_cur[2:0];
                    crmd[2:0]    <= 3'b000;
                    era          <= commit_i.pc;
                    estat[21:16] <= commit_i.ecode;
                    estat[30:22] <= commit_i.esubcode;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst_i)
        commit_i.valid && commit_i.ertn |-> commit_i.ecode == '0)
        else $error("csr_file: ertn commit carries an exception code");

endmodule

// File: verilog/csr_types.sv
`include "trap_defs.svh"

package csr_types;

    typedef enum logic [`TRAP_CSR_ADDR_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_EENTRY = 14'h00c,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    typedef enum logic [`TRAP_CAUSE_W-1:0] {
        EXC_NOP = 5'd0,
        EXC_INT, EXC_PIL, EXC_PIS, EXC_PIF, EXC_PME, EXC_PPI,
        EXC_ADEF, EXC_ADEM, EXC_ALE, EXC_SYS, EXC_BRK, EXC_INE,
        EXC_IPE, EXC_FPD, EXC_FPE, EXC_TLBR
    } exc_cause_e;

    // current csr values with the write-back write already applied.
    typedef struct packed {
        logic [`TRAP_DATA_W-1:0] crmd;
        logic [`TRAP_DATA_W-1:0] era;
        logic [`TRAP_DATA_W-1:0] eentry;
        logic [`TRAP_INT_W-1:0]  ecfg_lie;
        logic [`TRAP_INT_W-1:0]  estat_is;
    } csr_view_t;

    // ertn set means a return, otherwise valid is a trap entry.
    typedef struct packed {
        logic                     valid;
        logic                     ertn;
        logic [`TRAP_DATA_W-1:0]  pc;
        logic [`TRAP_ECODE_W-1:0] ecode;
        logic [`TRAP_ESUB_W-1:0]  esubcode;
    } trap_commit_t;

endpackage

// File: verilog/ctrl.sv
`timescale 1ns/100ps
`include "trap_defs.svh"

module ctrl (
    input  pipeline_types::mem_ctrl_t  mem_i,
    input  pipeline_types::pause_req_t pause_req_i,
    input  logic                       continue_idle_i,
    input  csr_types::csr_view_t       view_i,
    output pipeline_types::ctrl_out_t  ctrl_o,
    output csr_types::trap_commit_t    commit_o
);
    import csr_types::*;

    logic                     exc_any;
    logic                     ertn_take;
    logic [`TRAP_INT_W-1:0]   int_vec;
    logic                     int_pending;
    logic                     pause_idle;
    exc_cause_e               cause;
    logic [`TRAP_ECODE_W-1:0] ecode;
    logic [`TRAP_ESUB_W-1:0]  esubcode;

    assign exc_any = |mem_i.is_exception;
    // an exception on the same instruction wins over the return.
    assign ertn_take = mem_i.is_ertn && !exc_any;

    assign int_vec     = view_i.crmd[2] ? (view_i.ecfg_lie & view_i.estat_is) : '0;
    assign int_pending = |int_vec;

    // higher slots overwrite lower ones, so slot 5 has the last word.
    always_comb begin
        cause = EXC_NOP;
        for (int i = 0; i < `TRAP_EXC_SRC; i++) begin
            if (mem_i.is_exception[i]) begin
                // privileged ops in slot 2 outside plv 0 trap as ipe.
                if (i == 2 && mem_i.is_privilege && view_i.crmd[1:0] != 2'b00) begin
                    cause = EXC_IPE;
                end else begin
                    cause = mem_i.exc_cause[i];
                end
            end
        end
    end

    always_comb begin
        ecode    = 6'h00;
        esubcode = '0;
        case (cause)
            EXC_PIL:  ecode = 6'h01;
            EXC_PIS:  ecode = 6'h02;
            EXC_PIF:  ecode = 6'h03;
            EXC_PME:  ecode = 6'h04;
            EXC_PPI:  ecode = 6'h07;
            EXC_ADEF: ecode = 6'h08;
            EXC_ADEM: begin
                ecode    = 6'h08;
                esubcode = 9'h001;
            end
            EXC_ALE:  ecode = 6'h09;
            EXC_SYS:  ecode = 6'h0b;
            EXC_BRK:  ecode = 6'h0c;
            EXC_INE:  ecode = 6'h0d;
            EXC_IPE:  ecode = 6'h0e;
            EXC_FPD:  ecode = 6'h0f;
            EXC_FPE:  ecode = 6'h12;
            EXC_TLBR: ecode = 6'h3f;
            default:  ecode = 6'h00;
        endcase
    end

    assign ctrl_o.flush        = exc_any || mem_i.is_ertn;
    assign ctrl_o.redirect_pc  = ertn_take ? view_i.era : view_i.eentry;
    assign ctrl_o.is_interrupt = int_pending;

    assign commit_o.valid    = ctrl_o.flush;
    assign commit_o.ertn     = ertn_take;
    assign commit_o.pc       = mem_i.pc;
    assign commit_o.ecode    = ecode;
    assign commit_o.esubcode = esubcode;

    assign pause_idle = mem_i.is_idle && !int_pending && !continue_idle_i;

    // bit 0 is pc fetch, bit 6 is mem, write-back is never held.
    always_comb begin
        if (pause_req_i.pause_mem || pause_idle) begin
            ctrl_o.pause = 8'h7f;
        end else if (pause_req_i.pause_ex) begin
            ctrl_o.pause = 8'h3f;
        end else if (pause_req_i.pause_dispatch) begin
            ctrl_o.pause = 8'h1f;
        end else if (pause_req_i.pause_id) begin
            ctrl_o.pause = 8'h0f;
        end else if (pause_req_i.pause_if) begin
            ctrl_o.pause = 8'h01;
        end else begin
            ctrl_o.pause = 8'h00;
        end
    end

    always_comb begin
        if (ctrl_o.flush && !ertn_take) begin
            assert (cause != EXC_NOP)
                else $error("ctrl: flush raised by a slot with no cause");
        end
    end

endmodule

// File: verilog/pipeline_types.sv
`include "trap_defs.svh"

package pipeline_types;

    // retiring instruction as seen in the memory stage.
    typedef struct packed {
        logic [`TRAP_DATA_W-1:0]                   pc;
        logic [`TRAP_EXC_SRC-1:0]                  is_exception;
        csr_types::exc_cause_e [`TRAP_EXC_SRC-1:0] exc_cause;
        logic                                      is_ertn;
        logic                                      is_privilege;
        logic                                      is_idle;
    } mem_ctrl_t;

    typedef struct packed {
        logic pause_if;
        logic pause_id;
        logic pause_dispatch;
        logic pause_ex;
        logic pause_mem;
    } pause_req_t;

    // csr write leaving the write-back stage.
    typedef struct packed {
        logic                    en;
        csr_types::csr_addr_e    addr;
        logic [`TRAP_DATA_W-1:0] data;
    } wb_csr_t;

    typedef struct packed {
        logic                    flush;
        logic [`TRAP_DATA_W-1:0] redirect_pc;
        logic                    is_interrupt;
        logic [`TRAP_STAGES-1:0] pause;
    } ctrl_out_t;

endpackage

// File: verilog/timer_unit.sv
`timescale 1ns/100ps
`include "trap_defs.svh"

module timer_unit (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic [`TRAP_DATA_W-1:0] tcfg_i,
    input  logic                    tcfg_wr_i,
    output logic [`TRAP_DATA_W-1:0] tval_o,
    output logic                    irq_o
);

    logic                    active;
    logic [`TRAP_DATA_W-1:0] init_val;

    // tcfg holds the init value in 31:2 already scaled by four.
    assign init_val = {tcfg_i[`TRAP_DATA_W-1:2], 2'b00};
    assign irq_o    = active && (tval_o == '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            active <= 1'b0;
            tval_o <= '0;
        end else if (tcfg_wr_i) begin
            active <= tcfg_i[0];
            if (tcfg_i[0]) begin
                tval_o <= init_val;
            end
        end else if (active) begin
            if (tval_o != '0) begin
                tval_o <= tval_o - `TRAP_DATA_W'(1);
            end else if (tcfg_i[1]) begin
                tval_o <= init_val;
            end else begin
                // one-shot expiry parks the counter at all ones.
                active <= 1'b0;
                tval_o <= '1;
            end
        end
    end

endmodule

// File: verilog/trap_unit.sv
`timescale 1ns/100ps
`include "trap_defs.svh"

module trap_unit (
    input  logic                       clk,
    input  logic                       rst_i,
    input  pipeline_types::mem_ctrl_t  mem_i,
    input  pipeline_types::pause_req_t pause_req_i,
    input  logic                       continue_idle_i,
    input  pipeline_types::wb_csr_t    wb_i,
    input  logic [`TRAP_HWI_W-1:0]     hwi_i,
    input  csr_types::csr_addr_e       csr_raddr_i,
    output logic [`TRAP_DATA_W-1:0]    csr_rdata_o,
    output pipeline_types::ctrl_out_t  ctrl_o
);
    import csr_types::*;

    csr_view_t               view;
    trap_commit_t            commit;
    logic [`TRAP_DATA_W-1:0] tcfg;
    logic                    tcfg_wr;
    logic [`TRAP_DATA_W-1:0] tval;
    logic                    timer_irq;

    ctrl ctrl0 (
        .mem_i           (mem_i),
        .pause_req_i     (pause_req_i),
        .continue_idle_i (continue_idle_i),
        .view_i          (view),
        .ctrl_o          (ctrl_o),
        .commit_o        (commit)
    );

    csr_file csr0 (
        .clk         (clk),
        .rst_i       (rst_i),
        .wb_i        (wb_i),
        .commit_i    (commit),
        .hwi_i       (hwi_i),
        .timer_irq_i (timer_irq),
        .tval_i      (tval),
        .raddr_i     (csr_raddr_i),
        .rdata_o     (csr_rdata_o),
        .view_o      (view),
        .tcfg_o      (tcfg),
        .tcfg_wr_o   (tcfg_wr)
    );

    timer_unit timer0 (
        .clk       (clk),
        .rst_i     (rst_i),
        .tcfg_i    (tcfg),
        .tcfg_wr_i (tcfg_wr),
        .tval_o    (tval),
        .irq_o     (timer_irq)
    );

endmodule
